/* verilog/crypto_pkg.sv */
package crypto_pkg;

	// key material as loaded from the key stream
	typedef struct packed {
		logic [31:0] modulus;  // n
		logic [31:0] exponent; // private exponent d
		logic [31:0] digest;   // stored passphrase digest
	} key_material_t;

	// passphrase stage
	typedef enum logic [1:0] {
		ENTRY,
		COMPARE,
		UNLOCKED
	} unlock_state_e;

	// exponentiation stage
	typedef enum logic [1:0] {
		IDLE,
		SQUARE,
		MULTIPLY,
		DONE
	} modexp_state_e;

	localparam logic [31:0] DIGEST_MUL  = 32'd31; // digest = digest * 31 + code
	localparam logic [31:0] DIGEST_INIT = 32'd0;
	localparam logic [7:0]  ENTER_CODE  = 8'h0d;  // code sent along with done

endpackage

/* verilog/stream_pkg.sv */
package stream_pkg;

	// one keyboard event, already framed by the receiver
	typedef struct packed {
		logic [7:0] code;  // character byte
		logic       done;  // enter pressed
		logic       clear; // wipe the typed text
	} kbd_char_t;

	// one beat of a 32-bit word stream
	typedef struct packed {
		logic [31:0] data;
	} word_beat_t;

endpackage

/* verilog/key_store.sv */
`timescale 1ns/1ps

module key_store #(
	parameter int KEY_W = 32
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      key_valid_i,
	input  stream_pkg::word_beat_t    key_i,
	output logic                      key_ready_o,
	output crypto_pkg::key_material_t key_o,
	output logic                      key_loaded_o
);

	logic [1:0]                beat_cnt_q; // which word comes next
	logic                      loaded_q;
	crypto_pkg::key_material_t key_q;
	logic                      accept;

	assign accept       = key_valid_i && key_ready_o;
	assign key_ready_o  = !loaded_q; // drops on the edge that sets loaded
	assign key_loaded_o = loaded_q;
	assign key_o        = key_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			beat_cnt_q <= 2'd0;
			loaded_q   <= 1'b0;
		end else if (accept) begin
			beat_cnt_q <= beat_cnt_q + 2'd1;
			if (beat_cnt_q == 2'd2) begin
				loaded_q <= 1'b1; // key complete after the third word
			end
		end
	end

	// key words held until reset
	always_ff @(posedge clk) begin
		if (accept) begin
			case (beat_cnt_q)
				2'd0: key_q.modulus <= 32'(key_i.data[KEY_W-1:0]);
				2'd1: key_q.exponent <= 32'(key_i.data[KEY_W-1:0]);
				2'd2: key_q.digest <= key_i.data; // digest is always full width
				default: ;
			endcase
		end
	end

endmodule

/* verilog/passphrase_check.sv */
`timescale 1ns/1ps

module passphrase_check #(
	parameter int MAX_CHARS = 56
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  key_loaded_i,
	input  logic [31:0]           digest_i,
	input  logic                  kbd_valid_i,
	input  stream_pkg::kbd_char_t kbd_i,
	output logic                  unlocked_o,
	output logic                  led_pass_o,
	output logic                  led_fail_o
);

	localparam int CNT_W = $clog2(MAX_CHARS + 1);

	crypto_pkg::unlock_state_e state_q;
	logic [31:0]               digest_q; // running digest of typed text
	logic [CNT_W-1:0]          count_q;  // characters folded so far
	logic                      pass_q;
	logic                      fail_q;
	logic                      kbd_take;

	// keyboard is only listened to once the key is in
	assign kbd_take   = kbd_valid_i && key_loaded_i;
	assign unlocked_o = (state_q == crypto_pkg::UNLOCKED);
	assign led_pass_o = pass_q;
	assign led_fail_o = fail_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q  <= crypto_pkg::ENTRY;
			digest_q <= crypto_pkg::DIGEST_INIT;
			count_q  <= '0;
			pass_q   <= 1'b0;
			fail_q   <= 1'b0;
		end else begin
			case (state_q)
				crypto_pkg::ENTRY: begin
					if (kbd_take) begin
						if (kbd_i.clear) begin
							digest_q <= crypto_pkg::DIGEST_INIT; // start the text over
							count_q  <= '0;
						end else if (kbd_i.done) begin
							state_q <= crypto_pkg::COMPARE;
						end else begin
							digest_q <= digest_q * crypto_pkg::DIGEST_MUL + 32'(kbd_i.code);
							count_q  <= count_q + 1'b1;
							if (count_q == CNT_W'(MAX_CHARS - 1)) begin
								state_q <= crypto_pkg::COMPARE; // compare once the buffer is full
							end
						end
					end
				end
				crypto_pkg::COMPARE: begin
					if (digest_q == digest_i) begin
						state_q <= crypto_pkg::UNLOCKED;
						pass_q  <= 1'b1;
						fail_q  <= 1'b0;
					end else begin
						state_q  <= crypto_pkg::ENTRY; // try again
						fail_q   <= 1'b1;
						digest_q <= crypto_pkg::DIGEST_INIT;
						count_q  <= '0;
					end
				end
				default: ; // unlocked until reset
			endcase
		end
	end

endmodule

/* verilog/modexp_unit.sv */
`timescale 1ns/1ps

module modexp_unit #(
	parameter int KEY_W = 32
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             start_i,
	input  logic [KEY_W-1:0] base_i,
	input  logic [KEY_W-1:0] modulus_i,
	input  logic [KEY_W-1:0] exponent_i,
	output logic             busy_o,
	output logic [KEY_W-1:0] result_o,
	output logic             result_valid_o
);

	localparam int IDX_W = $clog2(KEY_W);
	localparam int CNT_W = $clog2(KEY_W + 1);

	crypto_pkg::modexp_state_e state_q;
	logic [KEY_W-1:0] n_q;
	logic [KEY_W-1:0] r_q;      // running result
	logic [KEY_W-1:0] base_q;   // base reduced mod n
	logic [KEY_W-1:0] exp_q;    // current exponent bit at the top
	logic [KEY_W-1:0] mcand_q;  // multiplicand always below n
	logic [KEY_W-1:0] mplier_q; // multiplier shifted out msb first
	logic [KEY_W:0]   acc_q;    // one spare bit for the doubled value
	logic [KEY_W:0]   acc_nxt;
	logic [CNT_W-1:0] cnt_q;
	logic [IDX_W-1:0] bits_q;   // exponent bits still below the current one
	logic [IDX_W-1:0] msb_idx;
	logic             first_q;  // first multiply also yields base mod n
	logic [KEY_W-1:0] one_mod;
	logic [KEY_W-1:0] res;

	assign one_mod        = (modulus_i == KEY_W'(1)) ? '0 : KEY_W'(1);
	assign res            = acc_q[KEY_W-1:0];
	assign busy_o         = (state_q == crypto_pkg::SQUARE) || (state_q == crypto_pkg::MULTIPLY);
	assign result_o       = r_q;
	assign result_valid_o = (state_q == crypto_pkg::DONE);

	always_comb begin : msb_scan
		msb_idx = '0;
		for (int i = 0; i < KEY_W; i++) begin
			if (exponent_i[i]) begin
				msb_idx = IDX_W'(i);
			end
		end
	end

	// one shift-add step computing 2*acc + bit*mcand mod n
	always_comb begin : mul_step
		logic [KEY_W:0] dbl;
		logic [KEY_W:0] sum;
		dbl = {acc_q[KEY_W-1:0], 1'b0};
		if (dbl >= {1'b0, n_q}) begin
			dbl = dbl - {1'b0, n_q};
		end
		sum = dbl + (mplier_q[KEY_W-1] ? {1'b0, mcand_q} : '0);
		if (sum >= {1'b0, n_q}) begin
			sum = sum - {1'b0, n_q};
		end
		acc_nxt = sum;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= crypto_pkg::IDLE;
			cnt_q   <= '0;
			bits_q  <= '0;
			first_q <= 1'b0;
		end else begin
			case (state_q)
				crypto_pkg::IDLE, crypto_pkg::DONE: begin
					state_q <= crypto_pkg::IDLE;
					if (start_i) begin
						n_q      <= modulus_i;
						r_q      <= one_mod; // result for a zero exponent
						exp_q    <= exponent_i << (KEY_W - 1 - msb_idx);
						bits_q   <= msb_idx;
						acc_q    <= '0;
						cnt_q    <= CNT_W'(KEY_W);
						mcand_q  <= one_mod; // square of 1 skipped at the top bit
						mplier_q <= base_i;
						first_q  <= 1'b1;
						state_q  <= (exponent_i == '0) ? crypto_pkg::DONE : crypto_pkg::MULTIPLY;
					end
				end
				default: begin
					if (cnt_q != '0) begin
						acc_q    <= acc_nxt;
						mplier_q <= mplier_q << 1;
						cnt_q    <= cnt_q - 1'b1;
					end else begin
						// product finished so write back and pick the next one
						r_q     <= res;
						acc_q   <= '0;
						cnt_q   <= CNT_W'(KEY_W);
						mcand_q <= res;
						first_q <= 1'b0;
						if (first_q) begin
							base_q <= res;
						end
						if (state_q == crypto_pkg::SQUARE && exp_q[KEY_W-1]) begin
							mplier_q <= base_q;
							state_q  <= crypto_pkg::MULTIPLY;
						end else if (bits_q == '0) begin
							state_q <= crypto_pkg::DONE; // last bit done
						end else begin
							exp_q    <= exp_q << 1;
							bits_q   <= bits_q - 1'b1;
							mplier_q <= res;
							state_q  <= crypto_pkg::SQUARE;
						end
					end
				end
			endcase
		end
	end

endmodule

/* verilog/session_key_out.sv */
`timescale 1ns/1ps

module session_key_out #(
	parameter int KEY_W = 32
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   unlocked_i,
	input  logic                   wrap_valid_i,
	input  stream_pkg::word_beat_t wrap_i,
	output logic                   wrap_ready_o,
	input  logic                   mx_busy_i,
	input  logic [KEY_W-1:0]       mx_result_i,
	input  logic                   mx_result_valid_i,
	output logic                   mx_start_o,
	output logic [KEY_W-1:0]       mx_base_o,
	input  logic                   out_ready_i,
	output logic                   out_valid_o,
	output stream_pkg::word_beat_t out_o
);

	logic                   out_valid_q;
	stream_pkg::word_beat_t out_q;
	logic                   pend_q;    // result waiting inside modexp_unit
	logic                   out_free;  // output register empty or draining
	logic                   take_result;

	assign out_free    = !out_valid_q || out_ready_i;
	assign take_result = (mx_result_valid_i || pend_q) && out_free;

	// no new word while a finished result still has nowhere to go
	assign wrap_ready_o = unlocked_i && !mx_busy_i && !pend_q &&
		!(mx_result_valid_i && !out_free);
	assign mx_start_o  = wrap_valid_i && wrap_ready_o;
	assign mx_base_o   = wrap_i.data[KEY_W-1:0];
	assign out_valid_o = out_valid_q;
	assign out_o       = out_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid_q <= 1'b0;
			pend_q      <= 1'b0;
		end else begin
			if (take_result) begin
				out_valid_q <= 1'b1;
			end else if (out_ready_i) begin
				out_valid_q <= 1'b0;
			end
			if (pend_q) begin
				pend_q <= !out_free;
			end else if (mx_result_valid_i && !out_free) begin
				pend_q <= 1'b1; // result stays held in the modexp result register
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take_result) begin
			out_q.data <= 32'(mx_result_i);
		end
	end

endmodule

/* verilog/key_unwrap_top.sv */
`timescale 1ns/1ps

module key_unwrap_top #(
	parameter int KEY_W     = 32,
	parameter int MAX_CHARS = 56
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   key_valid_i,
	output logic                   key_ready_o,
	input  stream_pkg::word_beat_t key_i,
	input  logic                   kbd_valid_i,
	input  stream_pkg::kbd_char_t  kbd_i,
	input  logic                   wrap_valid_i,
	output logic                   wrap_ready_o,
	input  stream_pkg::word_beat_t wrap_i,
	output logic                   out_valid_o,
	input  logic                   out_ready_i,
	output stream_pkg::word_beat_t out_o,
	output logic                   led_pass_o,
	output logic                   led_fail_o
);

	crypto_pkg::key_material_t key;
	logic                      key_loaded;
	logic                      unlocked;
	logic                      mx_start;
	logic [KEY_W-1:0]          mx_base;
	logic                      mx_busy;
	logic [KEY_W-1:0]          mx_result;
	logic                      mx_result_valid;

	key_store #(.KEY_W(KEY_W)) u_key_store (
		.clk          (clk),
		.rst          (rst),
		.key_valid_i  (key_valid_i),
		.key_i        (key_i),
		.key_ready_o  (key_ready_o),
		.key_o        (key),
		.key_loaded_o (key_loaded)
	);

	passphrase_check #(.MAX_CHARS(MAX_CHARS)) u_passphrase_check (
		.clk          (clk),
		.rst          (rst),
		.key_loaded_i (key_loaded),
		.digest_i     (key.digest),
		.kbd_valid_i  (kbd_valid_i),
		.kbd_i        (kbd_i),
		.unlocked_o   (unlocked),
		.led_pass_o   (led_pass_o),
		.led_fail_o   (led_fail_o)
	);

	modexp_unit #(.KEY_W(KEY_W)) u_modexp_unit (
		.clk            (clk),
		.rst            (rst),
		.start_i        (mx_start),
		.base_i         (mx_base),
		.modulus_i      (key.modulus[KEY_W-1:0]),
		.exponent_i     (key.exponent[KEY_W-1:0]),
		.busy_o         (mx_busy),
		.result_o       (mx_result),
		.result_valid_o (mx_result_valid)
	);

	session_key_out #(.KEY_W(KEY_W)) u_session_key_out (
		.clk               (clk),
		.rst               (rst),
		.unlocked_i        (unlocked),
		.wrap_valid_i      (wrap_valid_i),
		.wrap_i            (wrap_i),
		.wrap_ready_o      (wrap_ready_o),
		.mx_busy_i         (mx_busy),
		.mx_result_i       (mx_result),
		.mx_result_valid_i (mx_result_valid),
		.mx_start_o        (mx_start),
		.mx_base_o         (mx_base),
		.out_ready_i       (out_ready_i),
		.out_valid_o       (out_valid_o),
		.out_o             (out_o)
	);

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter int HALF_NS = 2 // 4 ns period
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever #(HALF_NS) clk_o = ~clk_o;
	end

endmodule

/* test/key_unwrap_tb.sv */
`timescale 1ns/1ps

module key_unwrap_tb;

	localparam int KEY_W     = 32;
	localparam int MAX_CHARS = 56;
	localparam int N_UNWRAP  = 20;
	localparam int N_STALL   = 12;
	localparam int TIMEOUT   = (N_UNWRAP + N_STALL) * 64 * 33 + 2000; // worst case per word

	logic                   clk, rst;
	logic                   key_valid_i, key_ready_o, kbd_valid_i;
	logic                   wrap_valid_i, wrap_ready_o, out_valid_o, out_ready_i;
	logic                   led_pass_o, led_fail_o;
	stream_pkg::word_beat_t key_i, wrap_i, out_o;
	stream_pkg::kbd_char_t  kbd_i;

	integer      seed;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          test_base;
	int          cycles = 0;
	string       cur_test;
	logic [31:0] expect_q[$]; // model results in output order
	logic [7:0]  pass_chars[$];
	logic [31:0] mod_n, exp_d, digest;
	logic        bp_on;       // random out_ready while set
	logic        held;        // output stalled at the last sample
	logic [31:0] held_word;

	tb_clock u_tb_clock (.clk_o(clk));

	key_unwrap_top #(.KEY_W(KEY_W), .MAX_CHARS(MAX_CHARS)) u_key_unwrap_top (.*);

	function automatic logic [31:0] fold_digest(input logic [7:0] chars[$]);
		logic [63:0] d;
		d = 64'd0;
		foreach (chars[i]) begin
			d = (d * 64'd31 + {56'd0, chars[i]}) & 64'hffff_ffff; // wraps at 32 bits
		end
		return d[31:0];
	endfunction

	// right-to-left binary method with products that fit in 64 bits
	function automatic logic [31:0] mod_pow(input logic [31:0] b, input logic [31:0] e,
		input logic [31:0] n);
		logic [63:0] r;
		logic [63:0] x;
		r = 64'd1 % {32'd0, n};
		x = {32'd0, b} % {32'd0, n};
		for (int i = 0; i < 32; i++) begin
			if (e[i]) r = (r * x) % {32'd0, n};
			x = (x * x) % {32'd0, n};
		end
		return r[31:0];
	endfunction

	function automatic logic [7:0] draw_char();
		return 8'(8'h21 + $unsigned($random(seed)) % 94); // printable ascii
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		$display("FAIL %s: %s expected %h, actual %h", cur_test, what, exp, act);
		errors++;
	endtask

	task automatic report_error(input string msg);
		$display("ERROR %s: %s", cur_test, msg);
		errors++;
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
	endtask

	// one valid/ready beat on the key or the wrapped stream
	task automatic send_beat(input logic to_wrap, input logic [31:0] w);
		logic taken;
		taken = 1'b0;
		if (to_wrap) begin
			expect_q.push_back(mod_pow(w, exp_d, mod_n));
			wrap_i.data  = w;
			wrap_valid_i = 1'b1;
		end else begin
			key_i.data  = w;
			key_valid_i = 1'b1;
		end
		while (!taken) begin
			@(negedge clk);
			taken = to_wrap ? wrap_ready_o : key_ready_o;
			step();
		end
		wrap_valid_i = 1'b0;
		key_valid_i  = 1'b0;
	endtask

	task automatic type_char(input logic [7:0] code, input logic done, input logic clear);
		kbd_i.code  = code;
		kbd_i.done  = done;
		kbd_i.clear = clear;
		kbd_valid_i = 1'b1;
		step();
		kbd_valid_i = 1'b0;
	endtask

	// text plus enter that returns at the negedge after the compare edge
	task automatic type_line(input logic [7:0] chars[$]);
		foreach (chars[i]) type_char(chars[i], 1'b0, 1'b0);
		type_char(crypto_pkg::ENTER_CODE, 1'b1, 1'b0);
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic drain();
		while (expect_q.size() != 0) @(posedge clk);
		repeat (4) @(posedge clk);
		@(negedge clk);
		if (out_valid_o) report_error("an output word came beyond the expected ones");
		step();
	endtask

	task automatic begin_test(input string name);
		cur_test  = name;
		test_base = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == test_base) begin
			$display("test %s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", cur_test, errors - test_base);
		end
	endtask

	always @(negedge clk) begin : out_monitor
		logic [31:0] want;
		if (rst) begin
			held = 1'b0;
		end else begin
			if (held && !out_valid_o) begin
				report_error("out_valid_o dropped before the word was taken");
			end
			if (held && out_valid_o && out_o.data !== held_word) begin
				report_mismatch("stalled out_o", held_word, out_o.data);
			end
			held      = out_valid_o && !out_ready_i;
			held_word = out_o.data;
			if (out_valid_o && out_ready_i) begin
				if (expect_q.size() == 0) begin
					report_error("an output word arrived with no wrapped word pending");
				end else begin
					want = expect_q.pop_front();
					if (out_o.data !== want) report_mismatch("out_o", want, out_o.data);
				end
			end
		end
	end

	// long stalls with short ready bursts
	initial begin : ready_driver
		int hold;
		out_ready_i = 1'b1;
		hold = 0;
		forever begin
			step();
			if (!bp_on) begin
				out_ready_i = 1'b1;
			end else if (hold > 0) begin
				hold--;
			end else begin
				out_ready_i = !out_ready_i;
				hold = int'($unsigned($random(seed)) % (out_ready_i ? 3 : 100));
			end
		end
	end

	always @(posedge clk) begin : watchdog
		cycles++;
		if (cycles > TIMEOUT) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin : main
		logic [7:0]  typo[$];
		logic [7:0]  junk[$];
		logic [31:0] words[$];
		logic [7:0]  c;
		int          idx;
		seed         = 32'h6096f649;
		bp_on        = 1'b0;
		rst          = 1'b1;
		key_valid_i  = 1'b0;
		key_i        = '0;
		kbd_valid_i  = 1'b0;
		kbd_i        = '0;
		wrap_valid_i = 1'b0;
		wrap_i       = '0;
		mod_n = $unsigned($random(seed)) | 32'd1; // odd modulus
		if (mod_n < 32'd3) mod_n = 32'd3;
		exp_d = $random(seed);
		repeat (4 + int'($unsigned($random(seed)) % 9)) pass_chars.push_back(draw_char());
		digest = fold_digest(pass_chars);

		begin_test("reset_state");
		apply_reset();
		@(negedge clk);
		if (key_ready_o !== 1'b1) report_mismatch("key_ready_o", 1, 32'(key_ready_o));
		if (wrap_ready_o !== 1'b0) report_mismatch("wrap_ready_o", 0, 32'(wrap_ready_o));
		if (out_valid_o !== 1'b0) report_mismatch("out_valid_o", 0, 32'(out_valid_o));
		if (led_pass_o !== 1'b0) report_mismatch("led_pass_o", 0, 32'(led_pass_o));
		if (led_fail_o !== 1'b0) report_mismatch("led_fail_o", 0, 32'(led_fail_o));
		step();
		send_beat(1'b0, mod_n);
		send_beat(1'b0, exp_d);
		send_beat(1'b0, digest);
		@(negedge clk);
		if (key_ready_o !== 1'b0) report_mismatch("key_ready_o", 0, 32'(key_ready_o));
		step();
		end_test();

		begin_test("wrong_passphrase");
		typo = pass_chars;
		idx  = int'($unsigned($random(seed)) % typo.size());
		c    = draw_char();
		while (c == typo[idx]) c = draw_char();
		typo[idx] = c; // one character off
		type_line(typo);
		if (led_fail_o !== 1'b1) report_mismatch("led_fail_o", 1, 32'(led_fail_o));
		if (led_pass_o !== 1'b0) report_mismatch("led_pass_o", 0, 32'(led_pass_o));
		if (wrap_ready_o !== 1'b0) report_mismatch("wrap_ready_o", 0, 32'(wrap_ready_o));
		step();
		end_test();

		begin_test("clear_entry");
		repeat (1 + int'($unsigned($random(seed)) % 3)) junk.push_back(draw_char());
		foreach (junk[i]) type_char(junk[i], 1'b0, 1'b0);
		type_char(8'h00, 1'b0, 1'b1);
		type_line(pass_chars);
		if (led_pass_o !== 1'b1) report_mismatch("led_pass_o", 1, 32'(led_pass_o));
		if (led_fail_o !== 1'b0) report_mismatch("led_fail_o", 0, 32'(led_fail_o));
		if (wrap_ready_o !== 1'b1) report_mismatch("wrap_ready_o", 1, 32'(wrap_ready_o));
		step();
		end_test();

		begin_test("unwrap");
		words.push_back(32'd0);
		words.push_back(32'd1);
		while (words.size() < N_UNWRAP) words.push_back($unsigned($random(seed)) % mod_n);
		foreach (words[i]) send_beat(1'b1, words[i]);
		drain();
		end_test();

		// new key with a one-bit exponent loaded after a fresh reset
		begin_test("back_pressure");
		mod_n = $unsigned($random(seed)) | 32'd1;
		if (mod_n < 32'd3) mod_n = 32'd3;
		exp_d = 32'd1 << ($unsigned($random(seed)) % 32);
		words.delete();
		repeat (N_STALL) words.push_back($unsigned($random(seed)) % mod_n);
		apply_reset();
		send_beat(1'b0, mod_n);
		send_beat(1'b0, exp_d);
		send_beat(1'b0, digest);
		type_line(pass_chars);
		if (led_pass_o !== 1'b1) report_mismatch("led_pass_o", 1, 32'(led_pass_o));
		step();
		bp_on = 1'b1;
		foreach (words[i]) send_beat(1'b1, words[i]);
		drain();
		bp_on = 1'b0;
		end_test();

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* verilog.f */
verilog/crypto_pkg.sv
verilog/stream_pkg.sv
verilog/key_store.sv
verilog/passphrase_check.sv
verilog/modexp_unit.sv
verilog/session_key_out.sv
verilog/key_unwrap_top.sv
test/tb_clock.sv
test/key_unwrap_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = key_unwrap_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = SIMULATION PASSED

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
